// File: project.f
+incdir+tb
hdl/idu_pkg.sv
hdl/gpr_file.sv
hdl/imm_gen.sv
hdl/inst_decoder.sv
hdl/idu_top.sv
tb/tb_idu_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the decode stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ns \
    -f project.f --top-module tb_idu_top -Mdir obj_dir; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_idu_top 2>&1)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "all tests passed"; then
  exit 0
else
  echo "pass message not found in simulation output"
  exit 1
fi

// File: tb/idu_vectors.svh
// decode vector table with instruction words, write-backs, expected immediates and controls
`ifndef IDU_VECTORS_SVH
`define IDU_VECTORS_SVH

  // columns: name, instruction, ifu ready, wb enable, wb register, immediate, controls
  task automatic load_vectors();
    add_vec("reset_state", 32'h002081B3, 0, 0, 0, 0, bad_ctrl(0));  // latch still cleared
    add_vec("add",       32'h002081B3, 1, 0, 0, 0, op_ctrl(ALU_ADD, 0, ALU_B_RS2, 0));
    add_vec("sub",       32'h402081B3, 1, 0, 0, 0, op_ctrl(ALU_SUB, 0, ALU_B_RS2, 0));
    add_vec("sra",       32'h4020D1B3, 1, 0, 0, 0, op_ctrl(ALU_SRA, 0, ALU_B_RS2, 0));
    add_vec("sltu",      32'h0020B1B3, 1, 0, 0, 0, op_ctrl(ALU_SLTU, 0, ALU_B_RS2, 0));
    add_vec("mul",       32'h022081B3, 1, 0, 0, 0, op_ctrl(ALU_MUL, 0, ALU_B_RS2, 0));
    add_vec("mulhu",     32'h0220B1B3, 1, 0, 0, 0, op_ctrl(ALU_MULHU, 0, ALU_B_RS2, 0));
    add_vec("remu",      32'h0220F1B3, 1, 0, 0, 0, op_ctrl(ALU_REMU, 0, ALU_B_RS2, 0));
    add_vec("addw",      32'h002081BB, 1, 0, 0, 0, op_ctrl(ALU_ADD, 0, ALU_B_RS2, 1));
    add_vec("addi_neg",  32'hFFD08293, 1, 0, 0, -3, op_ctrl(ALU_ADD, 0, ALU_B_IMM, 0));
    add_vec("addi_pos",  32'h7FF08293, 1, 0, 0, 2047, op_ctrl(ALU_ADD, 0, ALU_B_IMM, 0));
    add_vec("lui_neg",   32'h800002B7, 1, 0, 0, -64'sd2147483648,
            op_ctrl(ALU_COPY_IMM, 0, ALU_B_IMM, 0));
    add_vec("auipc_pos", 32'h12345297, 1, 0, 0, 'h12345000, op_ctrl(ALU_ADD, 1, ALU_B_IMM, 0));
    add_vec("sd_neg",    32'hFE20BC23, 1, 0, 0, -8, mem_ctrl(MEM_LD, 1));
    add_vec("sb_pos",    32'h06208223, 1, 0, 0, 100, mem_ctrl(MEM_LB, 1));
    add_vec("lb_neg",    32'hFFF08283, 1, 0, 0, -1, mem_ctrl(MEM_LB, 0));
    add_vec("lhu",       32'h0060D283, 1, 0, 0, 6, mem_ctrl(MEM_LHU, 0));
    add_vec("lwu",       32'h0000E283, 1, 0, 0, 0, mem_ctrl(MEM_LWU, 0));
    add_vec("ld",        32'h0100B283, 1, 0, 0, 16, mem_ctrl(MEM_LD, 0));
    add_vec("beq_pos",   32'h00208863, 1, 0, 0, 16, br_ctrl(BR_BEQ));
    add_vec("bne_neg",   32'hFE209EE3, 1, 0, 0, -4, br_ctrl(BR_BNE));
    add_vec("blt",       32'h0020C863, 1, 0, 0, 16, br_ctrl(BR_BLT));
    add_vec("bge",       32'h0020D863, 1, 0, 0, 16, br_ctrl(BR_BGE));
    add_vec("bltu",      32'h0020E863, 1, 0, 0, 16, br_ctrl(BR_BLTU));
    add_vec("bgeu",      32'h0020F863, 1, 0, 0, 16, br_ctrl(BR_BGEU));
    add_vec("jal_pos",   32'h001000EF, 1, 0, 0, 2048, jump_ctrl(BR_JAL));
    add_vec("jal_neg",   32'hFFFFF0EF, 1, 0, 0, -2, jump_ctrl(BR_JAL));
    add_vec("jalr",      32'h008280E7, 1, 0, 0, 8, jump_ctrl(BR_JALR));
    add_vec("ready_low", 32'h002081B3, 0, 0, 0, 8, jump_ctrl(BR_JALR));  // jalr held
    add_vec("wb_x7",     32'h007384B3, 1, 1, 7, 0, op_ctrl(ALU_ADD, 0, ALU_B_RS2, 0));
    add_vec("wb_x15",    32'h00F7F4B3, 1, 1, 15, 0, op_ctrl(ALU_AND, 0, ALU_B_RS2, 0));
    add_vec("wb_x0",     32'h000004B3, 1, 1, 0, 0, op_ctrl(ALU_ADD, 0, ALU_B_RS2, 0));
    add_vec("bad_opcode", 32'h0000007F, 1, 0, 0, 0, bad_ctrl(1));
    add_vec("ecall",     32'h00000073, 1, 0, 0, 0, bad_ctrl(1));
    add_vec("zero_word", 32'h00000000, 1, 0, 0, 0, bad_ctrl(0));
  endtask

`endif

// File: tb/tb_idu_top.sv
// testbench for the decode stage: clock, reset, watchdog, compare tasks and the vector loop
`timescale 1ns/1ns

module tb_idu_top import idu_pkg::*; ();

  typedef struct packed {
    logic [ALU_OP_W-1:0]  alu_op;
    logic                 a_pc;
    logic [1:0]           b_src;
    logic                 word_cut;
    logic                 reg_wr;
    logic                 mem_to_reg;
    logic                 mem_wr;
    logic                 mem_re;
    logic [MEM_OP_W-1:0]  mem_op;
    logic                 br_en;
    logic [BR_FUNC_W-1:0] br_func;
    logic                 invalid;
  } ctrl_t;

  typedef struct packed {
    logic [ILEN-1:0]       inst;
    logic                  ready;
    logic                  wb_en;
    logic [REG_ADDR_W-1:0] wb_addr;
    logic [XLEN-1:0]       imm;
    ctrl_t                 ctrl;
  } vec_t;

  logic                  i_clk;
  logic                  i_rst_n;
  logic                  i_ifu_ready;
  logic [ILEN-1:0]       i_inst;
  logic                  i_wb_wen;
  logic [REG_ADDR_W-1:0] i_wb_waddr;
  logic [XLEN-1:0]       i_wb_wdata;
  logic [REG_ADDR_W-1:0] o_rd;
  logic [XLEN-1:0]       o_rs1_data;
  logic [XLEN-1:0]       o_rs2_data;
  logic [XLEN-1:0]       o_imm;
  logic [ALU_OP_W-1:0]   o_alu_op;
  logic                  o_alu_a_pc;
  logic [1:0]            o_alu_b_src;
  logic                  o_word_cut;
  logic                  o_reg_wr;
  logic                  o_mem_to_reg;
  logic                  o_mem_wr;
  logic                  o_mem_re;
  logic [MEM_OP_W-1:0]   o_mem_op;
  logic                  o_br_en;
  logic [BR_FUNC_W-1:0]  o_br_func;
  logic                  o_invalid;

  ctrl_t dut_ctrl;
  vec_t  vecs[$];
  string vec_names[$];
  logic  loaded = 1'b0;

  idu_top u_dut (.*);

  assign dut_ctrl = {o_alu_op, o_alu_a_pc, o_alu_b_src, o_word_cut, o_reg_wr, o_mem_to_reg,
                     o_mem_wr, o_mem_re, o_mem_op, o_br_en, o_br_func, o_invalid};

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_ctrl(input string name, input ctrl_t exp, input ctrl_t act);
    ctrl_t got;
    got = act;
    if (exp.alu_op == ALU_INVALID) got.b_src = exp.b_src;  // no operand for a dead word
    if (!exp.br_en) got.br_func = exp.br_func;
    if (got !== exp) begin
      fail_run($sformatf("error %s: ctrl expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_imm(input string name, input logic [XLEN-1:0] exp,
                           input logic [XLEN-1:0] act);
    if (act !== exp) begin
      fail_run($sformatf("error %s: imm expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_reg(input string name, input logic [XLEN-1:0] exp,
                           input logic [XLEN-1:0] act);
    if (act !== exp) begin
      fail_run($sformatf("error %s: reg expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_rd(input string name, input logic [REG_ADDR_W-1:0] exp,
                          input logic [REG_ADDR_W-1:0] act);
    if (act !== exp) begin
      fail_run($sformatf("error %s: rd expected %0d actual %0d", name, exp, act));
    end
  endtask

  // expected controls per instruction class
  function automatic ctrl_t op_ctrl(input logic [ALU_OP_W-1:0] alu, input logic a_pc,
                                    input logic [1:0] b_src, input logic cut);
    ctrl_t c;
    c = '0;
    c.alu_op   = alu;
    c.a_pc     = a_pc;
    c.b_src    = b_src;
    c.word_cut = cut;
    c.reg_wr   = 1'b1;
    c.mem_op   = MEM_NONE;
    return c;
  endfunction

  function automatic ctrl_t mem_ctrl(input logic [MEM_OP_W-1:0] mem_op, input logic store);
    ctrl_t c;
    c = '0;
    c.alu_op     = ALU_ADD;  // base + offset
    c.b_src      = ALU_B_IMM;
    c.reg_wr     = !store;
    c.mem_to_reg = !store;
    c.mem_re     = !store;
    c.mem_wr     = store;
    c.mem_op     = mem_op;
    return c;
  endfunction

  function automatic ctrl_t jump_ctrl(input logic [BR_FUNC_W-1:0] br);
    ctrl_t c;
    c = op_ctrl(ALU_ADD, 1'b1, ALU_B_FOUR, 1'b0);
    c.br_en   = 1'b1;
    c.br_func = br;
    return c;
  endfunction

  function automatic ctrl_t br_ctrl(input logic [BR_FUNC_W-1:0] br);
    ctrl_t c;
    c = '0;
    c.alu_op  = ALU_SUB;  // compare rs1 with rs2
    c.b_src   = ALU_B_RS2;
    c.mem_op  = MEM_NONE;
    c.br_en   = 1'b1;
    c.br_func = br;
    return c;
  endfunction

  function automatic ctrl_t bad_ctrl(input logic invalid);
    ctrl_t c;
    c = '0;
    c.alu_op  = ALU_INVALID;
    c.mem_op  = MEM_NONE;
    c.invalid = invalid;
    return c;
  endfunction

  task automatic add_vec(input string name, input logic [ILEN-1:0] inst, input logic ready,
                         input logic wb_en, input logic [REG_ADDR_W-1:0] wb_addr,
                         input longint imm, input ctrl_t ctrl);
    vec_t v;
    v.inst    = inst;
    v.ready   = ready;
    v.wb_en   = wb_en;
    v.wb_addr = wb_addr;
    v.imm     = imm;
    v.ctrl    = ctrl;
    vecs.push_back(v);
    vec_names.push_back(name);
  endtask

`include "idu_vectors.svh"

  initial begin
    int timeout_ns;
    wait (loaded);
    timeout_ns = vecs.size() * 4 * 4 * 2;
    #(timeout_ns);
    fail_run("simulation timed out waiting for the vector loop");
  end

  initial begin
    vec_t                  v;
    logic [XLEN-1:0]       wdata;
    logic [XLEN-1:0]       exp_reg;
    logic [REG_ADDR_W-1:0] exp_rd;
    void'($urandom(77));
    i_rst_n     = 1'b0;
    i_ifu_ready = 1'b0;
    i_inst      = '0;
    i_wb_wen    = 1'b0;
    i_wb_waddr  = '0;
    i_wb_wdata  = '0;
    exp_rd      = '0;  // cleared latch
    load_vectors();
    loaded = 1'b1;
    repeat (3) @(posedge i_clk);
    i_rst_n <= 1'b1;
    for (int n = 0; n < vecs.size(); n++) begin
      v = vecs[n];
      wdata = {$urandom, $urandom};
      @(posedge i_clk);
      i_inst      <= v.inst;
      i_ifu_ready <= v.ready;
      i_wb_wen    <= v.wb_en;
      i_wb_waddr  <= v.wb_addr;
      i_wb_wdata  <= wdata;
      @(posedge i_clk);  // latch and write-back happen here
      i_ifu_ready <= 1'b0;
      i_wb_wen    <= 1'b0;
      @(negedge i_clk);
      if (v.ready) exp_rd = v.inst[11:7];  // rd field, held while ready is low
      check_ctrl(vec_names[n], v.ctrl, dut_ctrl);
      check_imm(vec_names[n], v.imm, o_imm);
      check_rd(vec_names[n], exp_rd, o_rd);
      if (v.wb_en) begin
        exp_reg = (v.wb_addr == 0) ? '0 : wdata;  // x0 stays zero
        check_reg(vec_names[n], exp_reg, o_rs1_data);
        check_reg(vec_names[n], exp_reg, o_rs2_data);
      end
    end
    $display("all tests passed");
    $finish;
  end

endmodule

// File: hdl/idu_top.sv
// decode stage top level with decoder, immediate generator and register file
`timescale 1ns/1ns

module idu_top import idu_pkg::*; (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  logic                  i_ifu_ready,
  input  logic [ILEN-1:0]       i_inst,
  input  logic                  i_wb_wen,
  input  logic [REG_ADDR_W-1:0] i_wb_waddr,
  input  logic [XLEN-1:0]       i_wb_wdata,
  output logic [REG_ADDR_W-1:0] o_rd,
  output logic [XLEN-1:0]       o_rs1_data,
  output logic [XLEN-1:0]       o_rs2_data,
  output logic [XLEN-1:0]       o_imm,
  output logic [ALU_OP_W-1:0]   o_alu_op,
  output logic                  o_alu_a_pc,
  output logic [1:0]            o_alu_b_src,
  output logic                  o_word_cut,
  output logic                  o_reg_wr,
  output logic                  o_mem_to_reg,
  output logic                  o_mem_wr,
  output logic                  o_mem_re,
  output logic [MEM_OP_W-1:0]   o_mem_op,
  output logic                  o_br_en,
  output logic [BR_FUNC_W-1:0]  o_br_func,
  output logic                  o_invalid
);

  inst_word_u            dec_inst;
  logic [IMM_SEL_W-1:0]  imm_sel;
  logic [REG_ADDR_W-1:0] rs1_idx;
  logic [REG_ADDR_W-1:0] rs2_idx;

  inst_decoder u_decoder (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_ifu_ready  (i_ifu_ready),
    .i_inst       (i_inst),
    .o_inst       (dec_inst),
    .o_imm_sel    (imm_sel),
    .o_rs1        (rs1_idx),
    .o_rs2        (rs2_idx),
    .o_rd         (o_rd),
    .o_alu_op     (o_alu_op),
    .o_alu_a_pc   (o_alu_a_pc),
    .o_alu_b_src  (o_alu_b_src),
    .o_word_cut   (o_word_cut),
    .o_reg_wr     (o_reg_wr),
    .o_mem_to_reg (o_mem_to_reg),
    .o_mem_wr     (o_mem_wr),
    .o_mem_re     (o_mem_re),
    .o_mem_op     (o_mem_op),
    .o_br_en      (o_br_en),
    .o_br_func    (o_br_func),
    .o_invalid    (o_invalid)
  );

  imm_gen u_imm_gen (
    .i_inst    (dec_inst),
    .i_imm_sel (imm_sel),
    .o_imm     (o_imm)
  );

  gpr_file u_gpr (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_raddr1 (rs1_idx),
    .i_raddr2 (rs2_idx),
    .i_wen    (i_wb_wen),
    .i_waddr  (i_wb_waddr),
    .i_wdata  (i_wb_wdata),
    .o_rdata1 (o_rs1_data),
    .o_rdata2 (o_rs2_data)
  );

endmodule

// File: hdl/inst_decoder.sv
// instruction latch and RV64IM decode into execution controls and immediate select
`timescale 1ns/1ns

module inst_decoder import idu_pkg::*; (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  logic                  i_ifu_ready,
  input  logic [ILEN-1:0]       i_inst,
  output inst_word_u            o_inst,
  output logic [IMM_SEL_W-1:0]  o_imm_sel,
  output logic [REG_ADDR_W-1:0] o_rs1,
  output logic [REG_ADDR_W-1:0] o_rs2,
  output logic [REG_ADDR_W-1:0] o_rd,
  output logic [ALU_OP_W-1:0]   o_alu_op,
  output logic                  o_alu_a_pc,
  output logic [1:0]            o_alu_b_src,
  output logic                  o_word_cut,
  output logic                  o_reg_wr,
  output logic                  o_mem_to_reg,
  output logic                  o_mem_wr,
  output logic                  o_mem_re,
  output logic [MEM_OP_W-1:0]   o_mem_op,
  output logic                  o_br_en,
  output logic [BR_FUNC_W-1:0]  o_br_func,
  output logic                  o_invalid
);

  inst_word_u           inst_q;
  logic [6:0]           opcode;
  logic [2:0]           funct3;
  logic [6:0]           funct7;
  logic                 shift_alt;
  logic                 legal;
  logic [ALU_OP_W-1:0]  alu_op;
  logic [IMM_SEL_W-1:0] imm_sel;
  logic [MEM_OP_W-1:0]  mem_op;
  logic [BR_FUNC_W-1:0] br_func;
  logic [1:0]           b_src;
  logic                 a_pc;
  logic                 word_cut;
  logic                 reg_wr;
  logic                 mem_re;
  logic                 mem_wr;
  logic                 br_en;

  function automatic logic [ALU_OP_W-1:0] base_alu(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  function automatic logic [ALU_OP_W-1:0] muldiv_alu(input logic [2:0] f3);
    case (f3)
      3'b000:  return ALU_MUL;
      3'b001:  return ALU_MULH;
      3'b010:  return ALU_MULHSU;
      3'b011:  return ALU_MULHU;
      3'b100:  return ALU_DIV;
      3'b101:  return ALU_DIVU;
      3'b110:  return ALU_REM;
      default: return ALU_REMU;
    endcase
  endfunction

  // access size and sign, same funct3 layout for loads and stores
  function automatic logic [MEM_OP_W-1:0] mem_code(input logic [2:0] f3);
    case (f3)
      3'b000:  return MEM_LB;
      3'b001:  return MEM_LH;
      3'b010:  return MEM_LW;
      3'b011:  return MEM_LD;
      3'b100:  return MEM_LBU;
      3'b101:  return MEM_LHU;
      3'b110:  return MEM_LWU;
      default: return MEM_NONE;
    endcase
  endfunction

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      inst_q <= '0;
    end else if (i_ifu_ready) begin
      inst_q <= i_inst;
    end
  end

  assign opcode    = inst_q.r.opcode;
  assign funct3    = inst_q.r.funct3;
  assign funct7    = inst_q.r.funct7;
  assign shift_alt = (funct3 == 3'b101) && (funct7[6:1] == FUNCT7_ALT[6:1]);  // srai, sraiw

  always_comb begin
    legal    = 1'b1;
    alu_op   = ALU_ADD;
    imm_sel  = IMM_R;
    mem_op   = MEM_NONE;
    br_func  = BR_JAL;
    b_src    = ALU_B_IMM;
    a_pc     = 1'b0;
    word_cut = 1'b0;
    reg_wr   = 1'b1;
    mem_re   = 1'b0;
    mem_wr   = 1'b0;
    br_en    = 1'b0;
    case (opcode)
      OPC_LUI: begin
        alu_op  = ALU_COPY_IMM;
        imm_sel = IMM_U;
      end
      OPC_AUIPC: begin
        imm_sel = IMM_U;
        a_pc    = 1'b1;
      end
      OPC_JAL, OPC_JALR: begin
        legal   = (opcode == OPC_JAL) || (funct3 == 3'b000);
        imm_sel = (opcode == OPC_JAL) ? IMM_J : IMM_I;
        br_func = (opcode == OPC_JAL) ? BR_JAL : BR_JALR;
        b_src   = ALU_B_FOUR;  // link address pc + 4
        a_pc    = 1'b1;
        br_en   = 1'b1;
      end
      OPC_BRANCH: begin
        legal   = (funct3[2:1] != 2'b01);
        alu_op  = ALU_SUB;
        imm_sel = IMM_B;
        b_src   = ALU_B_RS2;
        reg_wr  = 1'b0;
        br_en   = 1'b1;
        case (funct3)
          3'b000:  br_func = BR_BEQ;
          3'b001:  br_func = BR_BNE;
          3'b100:  br_func = BR_BLT;
          3'b101:  br_func = BR_BGE;
          3'b110:  br_func = BR_BLTU;
          default: br_func = BR_BGEU;
        endcase
      end
      OPC_LOAD: begin
        legal   = (funct3 != 3'b111);
        imm_sel = IMM_I;
        mem_op  = mem_code(funct3);
        mem_re  = 1'b1;
      end
      OPC_STORE: begin
        legal   = !funct3[2];  // sb, sh, sw, sd only
        imm_sel = IMM_S;
        mem_op  = mem_code(funct3);
        reg_wr  = 1'b0;
        mem_wr  = 1'b1;
      end
      OPC_OP_IMM: begin
        imm_sel = IMM_I;
        alu_op  = base_alu(funct3, shift_alt);
        if (funct3 == 3'b001) begin
          legal = (funct7[6:1] == FUNCT7_BASE[6:1]);  // 6-bit shamt
        end else if (funct3 == 3'b101) begin
          legal = (funct7[6:1] == FUNCT7_BASE[6:1]) || shift_alt;
        end
      end
      OPC_OP_IMM_32: begin
        imm_sel  = IMM_I;
        alu_op   = base_alu(funct3, shift_alt);
        word_cut = 1'b1;
        case (funct3)
          3'b000:  legal = 1'b1;
          3'b001:  legal = (funct7 == FUNCT7_BASE);
          3'b101:  legal = (funct7 == FUNCT7_BASE) || (funct7 == FUNCT7_ALT);
          default: legal = 1'b0;
        endcase
      end
      OPC_OP, OPC_OP_32: begin
        b_src    = ALU_B_RS2;
        word_cut = (opcode == OPC_OP_32);
        if (funct7 == FUNCT7_MULDIV) begin
          alu_op = muldiv_alu(funct3);
          legal  = !word_cut || (funct3 == 3'b000) || funct3[2];  // mulw, div/rem w forms
        end else if (funct7 == FUNCT7_ALT) begin
          alu_op = base_alu(funct3, 1'b1);
          legal  = (funct3 == 3'b000) || (funct3 == 3'b101);
        end else begin
          alu_op = base_alu(funct3, 1'b0);
          legal  = (funct7 == FUNCT7_BASE) &&
                   (!word_cut || (funct3 == 3'b000) || (funct3 == 3'b001) ||
                    (funct3 == 3'b101));
        end
      end
      default: begin
        legal = 1'b0;
      end
    endcase
  end

  assign o_inst       = inst_q;
  assign o_rs1        = inst_q.r.rs1;
  assign o_rs2        = inst_q.r.rs2;
  assign o_rd         = inst_q.r.rd;
  assign o_imm_sel    = legal ? imm_sel : IMM_R;
  assign o_alu_op     = legal ? alu_op : ALU_INVALID;
  assign o_alu_a_pc   = legal & a_pc;
  assign o_alu_b_src  = b_src;
  assign o_word_cut   = legal & word_cut;
  assign o_reg_wr     = legal & reg_wr;
  assign o_mem_re     = legal & mem_re;
  assign o_mem_to_reg = legal & mem_re;
  assign o_mem_wr     = legal & mem_wr;
  assign o_mem_op     = legal ? mem_op : MEM_NONE;
  assign o_br_en      = legal & br_en;
  assign o_br_func    = br_func;
  assign o_invalid    = !legal && (inst_q != '0);  // zero word is a bubble

  a_invalid_no_wr: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(o_invalid && o_reg_wr));

  a_mem_rw_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(o_mem_wr && o_mem_re));

endmodule

// File: hdl/imm_gen.sv
// sign-extended immediate assembly for the I, U, S, B and J formats
`timescale 1ns/1ns

module imm_gen import idu_pkg::*; (
  input  inst_word_u           i_inst,
  input  logic [IMM_SEL_W-1:0] i_imm_sel,
  output logic [XLEN-1:0]      o_imm
);

  always_comb begin
    case (i_imm_sel)
      IMM_I: begin
        o_imm = {{(XLEN-12){i_inst.i.imm_11_0[11]}}, i_inst.i.imm_11_0};
      end
      IMM_U: begin
        o_imm = {{(XLEN-32){i_inst.u.imm_31_12[19]}}, i_inst.u.imm_31_12, 12'b0};
      end
      IMM_S: begin
        o_imm = {{(XLEN-12){i_inst.s.imm_11_5[6]}}, i_inst.s.imm_11_5, i_inst.s.imm_4_0};
      end
      IMM_B: begin
        o_imm = {{(XLEN-13){i_inst.b.imm_12}}, i_inst.b.imm_12, i_inst.b.imm_11,
                 i_inst.b.imm_10_5, i_inst.b.imm_4_1, 1'b0};  // halfword aligned
      end
      IMM_J: begin
        o_imm = {{(XLEN-21){i_inst.j.imm_20}}, i_inst.j.imm_20, i_inst.j.imm_19_12,
                 i_inst.j.imm_11, i_inst.j.imm_10_1, 1'b0};
      end
      default: begin
        o_imm = '0;  // IMM_R
      end
    endcase
  end

endmodule

// File: hdl/gpr_file.sv
// 32 x 64-bit general register file, two read ports, one write port, x0 tied to zero
`timescale 1ns/1ns

module gpr_file import idu_pkg::*; (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  logic [REG_ADDR_W-1:0] i_raddr1,
  input  logic [REG_ADDR_W-1:0] i_raddr2,
  input  logic                  i_wen,
  input  logic [REG_ADDR_W-1:0] i_waddr,
  input  logic [XLEN-1:0]       i_wdata,
  output logic [XLEN-1:0]       o_rdata1,
  output logic [XLEN-1:0]       o_rdata2
);

  logic [XLEN-1:0] regs [NUM_REGS];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int k = 0; k < NUM_REGS; k++) begin
        regs[k] <= '0;
      end
    end else if (i_wen && (i_waddr != '0)) begin  // x0 writes dropped
      regs[i_waddr] <= i_wdata;
    end
  end

  // no bypass, a write shows up after its edge
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

  a_waddr_known: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_wen |-> !$isunknown(i_waddr));

endmodule

// File: hdl/idu_pkg.sv
// widths, RV64IM opcodes and function codes, control encodings, instruction word union
package idu_pkg;

  localparam int XLEN       = 64;
  localparam int ILEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;
  localparam int ALU_OP_W   = 5;
  localparam int MEM_OP_W   = 3;
  localparam int BR_FUNC_W  = 3;
  localparam int IMM_SEL_W  = 3;

  // major opcodes
  localparam logic [6:0] OPC_LUI       = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
  localparam logic [6:0] OPC_JAL       = 7'b1101111;
  localparam logic [6:0] OPC_JALR      = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
  localparam logic [6:0] OPC_LOAD      = 7'b0000011;
  localparam logic [6:0] OPC_STORE     = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_OP        = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
  localparam logic [6:0] OPC_OP_32     = 7'b0111011;

  localparam logic [6:0] FUNCT7_BASE   = 7'b0000000;
  localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;  // sub, sra
  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

  localparam logic [ALU_OP_W-1:0] ALU_ADD      = 5'd0;
  localparam logic [ALU_OP_W-1:0] ALU_SUB      = 5'd1;
  localparam logic [ALU_OP_W-1:0] ALU_SLT      = 5'd2;
  localparam logic [ALU_OP_W-1:0] ALU_SLTU     = 5'd3;
  localparam logic [ALU_OP_W-1:0] ALU_XOR      = 5'd4;
  localparam logic [ALU_OP_W-1:0] ALU_AND      = 5'd5;
  localparam logic [ALU_OP_W-1:0] ALU_OR       = 5'd6;
  localparam logic [ALU_OP_W-1:0] ALU_SLL      = 5'd7;
  localparam logic [ALU_OP_W-1:0] ALU_SRL      = 5'd8;
  localparam logic [ALU_OP_W-1:0] ALU_SRA      = 5'd9;
  localparam logic [ALU_OP_W-1:0] ALU_MUL      = 5'd10;
  localparam logic [ALU_OP_W-1:0] ALU_DIV      = 5'd11;
  localparam logic [ALU_OP_W-1:0] ALU_DIVU     = 5'd12;
  localparam logic [ALU_OP_W-1:0] ALU_REM      = 5'd13;
  localparam logic [ALU_OP_W-1:0] ALU_REMU     = 5'd14;
  localparam logic [ALU_OP_W-1:0] ALU_COPY_IMM = 5'd15;
  localparam logic [ALU_OP_W-1:0] ALU_MULH     = 5'd25;
  localparam logic [ALU_OP_W-1:0] ALU_MULHSU   = 5'd26;
  localparam logic [ALU_OP_W-1:0] ALU_MULHU    = 5'd27;
  localparam logic [ALU_OP_W-1:0] ALU_INVALID  = 5'd31;

  // stores reuse the signed codes
  localparam logic [MEM_OP_W-1:0] MEM_LB   = 3'd0;
  localparam logic [MEM_OP_W-1:0] MEM_LBU  = 3'd1;
  localparam logic [MEM_OP_W-1:0] MEM_LH   = 3'd2;
  localparam logic [MEM_OP_W-1:0] MEM_LHU  = 3'd3;
  localparam logic [MEM_OP_W-1:0] MEM_LW   = 3'd4;
  localparam logic [MEM_OP_W-1:0] MEM_LWU  = 3'd5;
  localparam logic [MEM_OP_W-1:0] MEM_LD   = 3'd6;
  localparam logic [MEM_OP_W-1:0] MEM_NONE = 3'd7;

  localparam logic [BR_FUNC_W-1:0] BR_JAL  = 3'd0;
  localparam logic [BR_FUNC_W-1:0] BR_JALR = 3'd1;
  localparam logic [BR_FUNC_W-1:0] BR_BEQ  = 3'd2;
  localparam logic [BR_FUNC_W-1:0] BR_BNE  = 3'd3;
  localparam logic [BR_FUNC_W-1:0] BR_BLT  = 3'd4;
  localparam logic [BR_FUNC_W-1:0] BR_BGE  = 3'd5;
  localparam logic [BR_FUNC_W-1:0] BR_BLTU = 3'd6;
  localparam logic [BR_FUNC_W-1:0] BR_BGEU = 3'd7;

  localparam logic [IMM_SEL_W-1:0] IMM_I = 3'd0;
  localparam logic [IMM_SEL_W-1:0] IMM_U = 3'd1;
  localparam logic [IMM_SEL_W-1:0] IMM_S = 3'd2;
  localparam logic [IMM_SEL_W-1:0] IMM_B = 3'd3;
  localparam logic [IMM_SEL_W-1:0] IMM_J = 3'd4;
  localparam logic [IMM_SEL_W-1:0] IMM_R = 3'd7;  // no immediate

  localparam logic [1:0] ALU_B_RS2  = 2'd0;
  localparam logic [1:0] ALU_B_IMM  = 2'd1;
  localparam logic [1:0] ALU_B_FOUR = 2'd2;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } inst_word_u;

endpackage
